// File: source/issue_defs.svh
// ############################
// Widths and lane indices
// ############################
`ifndef ISSUE_DEFS_SVH
`define ISSUE_DEFS_SVH

// Data and register index widths
`define XLEN        32
`define REG_ADDR_W  5

// Execution lanes, also the bit order of the busy vector
`define NUM_LANES   5
`define LANE_ALU    0
`define LANE_BR     1
`define LANE_MDU0   2
`define LANE_MDU1   3
`define LANE_LSU    4

`endif

// File: source/isa_pkg.sv
// ############################
// Opcode and lane command enums
// ############################
package isa_pkg;

    // Decoded opcodes of the supported subset
    typedef enum logic [5:0] {
        OP_NOP, OP_FENCE,
        // Integer arithmetic and logic
        OP_LUI, OP_AUIPC, OP_ADDI, OP_XORI, OP_ORI, OP_ANDI,
        OP_ADD, OP_SUB, OP_OR, OP_AND, OP_XOR,
        // Compare, jumps and branches
        OP_SLTI, OP_SLTIU, OP_JAL, OP_JALR, OP_SLT, OP_SLTU,
        OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU,
        OP_ECALL, OP_EBREAK, OP_MRET,
        // Shifts, multiply and divide
        OP_SLLI, OP_SRLI, OP_SRAI, OP_SLL, OP_SRL, OP_SRA,
        OP_MUL, OP_MULH, OP_MULHU, OP_MULHSU,
        OP_DIV, OP_DIVU, OP_REM, OP_REMU,
        // Loads and stores
        OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU,
        OP_SB, OP_SH, OP_SW
    } opcodes_t;

    // Lane commands, C_NONE must stay at zero (idle lane)
    typedef enum logic [5:0] {
        C_NONE = 6'd0,
        C_ADD, C_SUB, C_XOR, C_OR, C_AND,
        C_SLT, C_SLTU,
        C_BEQ, C_BNE, C_BLT, C_BGE, C_BLTU, C_BGEU,
        C_JAL, C_JALR,
        C_ECALL, C_EBREAK, C_MRET,
        C_SLL, C_SRL, C_SRA,
        C_MUL, C_MULH, C_MULHU, C_MULHSU,
        C_DIV, C_DIVU, C_REM, C_REMU,
        C_LB, C_LH, C_LW, C_LBU, C_LHU,
        C_SB, C_SH, C_SW
    } alu_cmd_t;

endpackage

// File: source/issue_pkg.sv
// ############################
// Decoded instruction, lane request
// and lane class types
// ############################
`include "issue_defs.svh"

package issue_pkg;
    import isa_pkg::*;

    // Instruction as delivered by the decoder
    typedef struct packed {
        logic [`REG_ADDR_W-1:0] rs1;
        logic [`REG_ADDR_W-1:0] rs2;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`XLEN-1:0]       imm;
        logic [`XLEN-1:0]       addr;
        opcodes_t               opcode;
        logic                   branch_taken;
    } dec_instr_t;

    // Lane class of an instruction, MDU covers both multiply lanes
    typedef enum logic [2:0] {
        CLS_ALU,
        CLS_BR,
        CLS_MDU,
        CLS_LSU
    } lane_class_t;

    // Request on one execution lane, all zero when idle
    typedef struct packed {
        alu_cmd_t               cmd;
        logic [`XLEN-1:0]       arg0;
        logic [`XLEN-1:0]       arg1;
        logic [`XLEN-1:0]       addr;
        logic [`XLEN-1:0]       imm;
        logic [`REG_ADDR_W-1:0] rd;
    } lane_req_t;

    // Branch lane adds the prediction made by the front end
    typedef struct packed {
        lane_req_t req;
        logic      predict_taken;
    } branch_req_t;

endpackage

// File: source/issue_hold_stage.sv
// ############################
// Waiting register for the
// decoded instruction
// ############################
`timescale 1ns/1ps

module issue_hold_stage
    import issue_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       i_flush,
    input  logic       i_stall,
    input  logic       i_dec_valid,
    input  dec_instr_t i_dec_instr,
    output logic       o_held_valid,
    output dec_instr_t o_held_instr
);

    // Valid bit, flush wins over a new instruction in the same cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_held_valid <= 1'b0;
        end else if (i_flush) begin
            o_held_valid <= 1'b0;
        end else if (!i_stall) begin
            o_held_valid <= i_dec_valid;
        end
    end

    // Instruction fields, only captured when a valid one comes in
    always_ff @(posedge clk) begin
        if (!i_stall && i_dec_valid) begin
            o_held_instr <= i_dec_instr;
        end
    end

endmodule

// File: source/issue_classify.sv
// ############################
// Opcode to lane class and command,
// operand selection
// ############################
`timescale 1ns/1ps
`include "issue_defs.svh"

module issue_classify
    import isa_pkg::*;
    import issue_pkg::*;
(
    input  dec_instr_t             i_held_instr,
    input  logic [`XLEN-1:0]       i_reg_rd0,
    input  logic [`XLEN-1:0]       i_reg_rd1,
    output logic [`REG_ADDR_W-1:0] o_reg_ra0,
    output logic [`REG_ADDR_W-1:0] o_reg_ra1,
    output lane_class_t            o_cls,
    output lane_req_t              o_req
);

    alu_cmd_t cmd;
    logic     arg1_imm;
    logic     rd_zero;

    // Register file read addresses come straight from the held instruction
    assign o_reg_ra0 = i_held_instr.rs1;
    assign o_reg_ra1 = i_held_instr.rs2;

    // Lane class and immediate select
    always_comb begin
        o_cls    = CLS_ALU;
        arg1_imm = 1'b0;
        rd_zero  = 1'b0;
        case (i_held_instr.opcode)
            // Executed as an add whose result is dropped
            OP_NOP, OP_FENCE: rd_zero = 1'b1;
            OP_LUI, OP_AUIPC, OP_ADDI, OP_XORI, OP_ORI, OP_ANDI: arg1_imm = 1'b1;
            OP_ADD, OP_SUB, OP_OR, OP_AND, OP_XOR: o_cls = CLS_ALU;
            OP_SLTI, OP_SLTIU, OP_JAL, OP_JALR: begin
                o_cls    = CLS_BR;
                arg1_imm = 1'b1;
            end
            OP_SLT, OP_SLTU, OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU,
            OP_ECALL, OP_EBREAK, OP_MRET: o_cls = CLS_BR;
            OP_SLLI, OP_SRLI, OP_SRAI: begin
                o_cls    = CLS_MDU;
                arg1_imm = 1'b1;
            end
            OP_SLL, OP_SRL, OP_SRA, OP_MUL, OP_MULH, OP_MULHU, OP_MULHSU,
            OP_DIV, OP_DIVU, OP_REM, OP_REMU: o_cls = CLS_MDU;
            OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU,
            OP_SB, OP_SH, OP_SW: o_cls = CLS_LSU;
            default: o_cls = CLS_ALU;
        endcase
    end

    // Lane command, register and immediate forms share one command
    always_comb begin
        case (i_held_instr.opcode)
            OP_NOP, OP_FENCE, OP_LUI, OP_AUIPC, OP_ADDI, OP_ADD: cmd = C_ADD;
            OP_SUB:             cmd = C_SUB;
            OP_XORI, OP_XOR:    cmd = C_XOR;
            OP_ORI, OP_OR:      cmd = C_OR;
            OP_ANDI, OP_AND:    cmd = C_AND;
            OP_SLTI, OP_SLT:    cmd = C_SLT;
            OP_SLTIU, OP_SLTU:  cmd = C_SLTU;
            OP_BEQ:             cmd = C_BEQ;
            OP_BNE:             cmd = C_BNE;
            OP_BLT:             cmd = C_BLT;
            OP_BGE:             cmd = C_BGE;
            OP_BLTU:            cmd = C_BLTU;
            OP_BGEU:            cmd = C_BGEU;
            OP_JAL:             cmd = C_JAL;
            OP_JALR:            cmd = C_JALR;
            OP_ECALL:           cmd = C_ECALL;
            OP_EBREAK:          cmd = C_EBREAK;
            OP_MRET:            cmd = C_MRET;
            OP_SLLI, OP_SLL:    cmd = C_SLL;
            OP_SRLI, OP_SRL:    cmd = C_SRL;
            OP_SRAI, OP_SRA:    cmd = C_SRA;
            OP_MUL:             cmd = C_MUL;
            OP_MULH:            cmd = C_MULH;
            OP_MULHU:           cmd = C_MULHU;
            OP_MULHSU:          cmd = C_MULHSU;
            OP_DIV:             cmd = C_DIV;
            OP_DIVU:            cmd = C_DIVU;
            OP_REM:             cmd = C_REM;
            OP_REMU:            cmd = C_REMU;
            OP_LB:              cmd = C_LB;
            OP_LH:              cmd = C_LH;
            OP_LW:              cmd = C_LW;
            OP_LBU:             cmd = C_LBU;
            OP_LHU:             cmd = C_LHU;
            OP_SB:              cmd = C_SB;
            OP_SH:              cmd = C_SH;
            OP_SW:              cmd = C_SW;
            default:            cmd = C_NONE;
        endcase
    end

    // Request as seen by the lane
    always_comb begin
        o_req.cmd  = cmd;
        o_req.arg0 = i_reg_rd0;
        o_req.arg1 = arg1_imm ? i_held_instr.imm : i_reg_rd1;
        o_req.addr = i_held_instr.addr;
        o_req.imm  = i_held_instr.imm;
        o_req.rd   = rd_zero ? '0 : i_held_instr.rd;
    end

endmodule

// File: source/issue_dispatch.sv
// ############################
// Lane selection, load strobes
// and stall
// ############################
`timescale 1ns/1ps
`include "issue_defs.svh"

module issue_dispatch
    import issue_pkg::*;
(
    input  logic                  i_held_valid,
    input  lane_class_t           i_cls,
    input  logic [`NUM_LANES-1:0] i_lane_busy,
    output logic [`NUM_LANES-1:0] o_load,
    output logic                  o_stall
);

    // One-hot target lane for the held class
    logic [`NUM_LANES-1:0] target_oh;
    logic                  target_free;

    always_comb begin
        target_oh = '0;
        case (i_cls)
            CLS_BR:  target_oh[`LANE_BR] = 1'b1;
            CLS_LSU: target_oh[`LANE_LSU] = 1'b1;
            CLS_MDU: begin
                // MDU0 first, MDU1 only takes over while MDU0 is busy
                if (!i_lane_busy[`LANE_MDU0]) begin
                    target_oh[`LANE_MDU0] = 1'b1;
                end else begin
                    target_oh[`LANE_MDU1] = 1'b1;
                end
            end
            default: target_oh[`LANE_ALU] = 1'b1;
        endcase
    end

    assign target_free = |(target_oh & ~i_lane_busy);

    // At most one strobe since the target is one-hot
    assign o_load  = i_held_valid ? (target_oh & ~i_lane_busy) : '0;
    assign o_stall = i_held_valid & ~target_free;

endmodule

// File: source/issue_lane_reg.sv
// ############################
// Output register of one lane
// ############################
`timescale 1ns/1ps

module issue_lane_reg #(
    parameter type payload_t = logic [7:0]
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     i_flush,
    input  logic     i_load,
    input  payload_t i_payload,
    output payload_t o_payload
);

    // A request lives for one cycle, the all-zero payload is the idle lane
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_payload <= '0;
        end else if (i_flush || !i_load) begin
            o_payload <= '0;
        end else begin
            o_payload <= i_payload;
        end
    end

endmodule

// File: source/issue_top.sv
// ############################
// Issue stage top level
// ############################
`timescale 1ns/1ps
`include "issue_defs.svh"

module issue_top
    import issue_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   i_flush,

    // Decoder side
    input  logic                   i_dec_valid,
    input  dec_instr_t             i_dec_instr,
    output logic                   o_dec_busy,

    // Register file read port, data returns in the same cycle
    output logic [`REG_ADDR_W-1:0] o_reg_ra0,
    output logic [`REG_ADDR_W-1:0] o_reg_ra1,
    input  logic [`XLEN-1:0]       i_reg_rd0,
    input  logic [`XLEN-1:0]       i_reg_rd1,

    // Execution lanes
    input  logic [`NUM_LANES-1:0]  i_lane_busy,
    output lane_req_t              o_lane_alu,
    output branch_req_t            o_lane_br,
    output lane_req_t              o_lane_mdu0,
    output lane_req_t              o_lane_mdu1,
    output lane_req_t              o_lane_lsu
);

    logic                  held_valid;
    dec_instr_t            held_instr;
    lane_req_t             req;
    lane_class_t           cls;
    logic [`NUM_LANES-1:0] load;
    logic                  stall;
    branch_req_t           br_req;

    issue_hold_stage issue_hold_stage_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_flush      (i_flush),
        .i_stall      (stall),
        .i_dec_valid  (i_dec_valid),
        .i_dec_instr  (i_dec_instr),
        .o_held_valid (held_valid),
        .o_held_instr (held_instr)
    );

    issue_classify issue_classify_inst (
        .i_held_instr (held_instr),
        .i_reg_rd0    (i_reg_rd0),
        .i_reg_rd1    (i_reg_rd1),
        .o_reg_ra0    (o_reg_ra0),
        .o_reg_ra1    (o_reg_ra1),
        .o_cls        (cls),
        .o_req        (req)
    );

    issue_dispatch issue_dispatch_inst (
        .i_held_valid (held_valid),
        .i_cls        (cls),
        .i_lane_busy  (i_lane_busy),
        .o_load       (load),
        .o_stall      (stall)
    );

    // Decoder waits as long as the held instruction cannot leave
    assign o_dec_busy = stall;

    // Branch lane carries the front end prediction along
    assign br_req.req           = req;
    assign br_req.predict_taken = held_instr.branch_taken;

    issue_lane_reg #(.payload_t(lane_req_t)) lane_alu_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .i_flush   (i_flush),
        .i_load    (load[`LANE_ALU]),
        .i_payload (req),
        .o_payload (o_lane_alu)
    );

    issue_lane_reg #(.payload_t(branch_req_t)) lane_br_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .i_flush   (i_flush),
        .i_load    (load[`LANE_BR]),
        .i_payload (br_req),
        .o_payload (o_lane_br)
    );

    issue_lane_reg #(.payload_t(lane_req_t)) lane_mdu0_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .i_flush   (i_flush),
        .i_load    (load[`LANE_MDU0]),
        .i_payload (req),
        .o_payload (o_lane_mdu0)
    );

    issue_lane_reg #(.payload_t(lane_req_t)) lane_mdu1_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .i_flush   (i_flush),
        .i_load    (load[`LANE_MDU1]),
        .i_payload (req),
        .o_payload (o_lane_mdu1)
    );

    issue_lane_reg #(.payload_t(lane_req_t)) lane_lsu_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .i_flush   (i_flush),
        .i_load    (load[`LANE_LSU]),
        .i_payload (req),
        .o_payload (o_lane_lsu)
    );

endmodule

// File: tests/issue_props.sv
// ##############################
// Handshake and lane output
// properties of the issue stage
// ##############################
`timescale 1ns/1ps

module issue_props
    import isa_pkg::*;
    import issue_pkg::*;
(
    input logic        clk,
    input logic        rst_n,
    input logic        held_valid,
    input logic        o_dec_busy,
    input lane_req_t   o_lane_alu,
    input branch_req_t o_lane_br,
    input lane_req_t   o_lane_mdu0,
    input lane_req_t   o_lane_mdu1,
    input lane_req_t   o_lane_lsu
);

    logic [4:0] active;

    assign active = {o_lane_lsu.cmd != C_NONE, o_lane_mdu1.cmd != C_NONE,
                     o_lane_mdu0.cmd != C_NONE, o_lane_br.req.cmd != C_NONE,
                     o_lane_alu.cmd != C_NONE};

    // Only one instruction leaves per cycle
    one_lane: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(active))
        else $error("more than one lane carries a request");

    // A request is never repeated on the same lane
    alu_once: assert property (@(posedge clk) disable iff (!rst_n)
        active[0] |=> o_lane_alu != $past(o_lane_alu))
        else $error("ALU request held longer than one cycle");
    br_once: assert property (@(posedge clk) disable iff (!rst_n)
        active[1] |=> o_lane_br != $past(o_lane_br))
        else $error("branch request held longer than one cycle");
    mdu0_once: assert property (@(posedge clk) disable iff (!rst_n)
        active[2] |=> o_lane_mdu0 != $past(o_lane_mdu0))
        else $error("MDU0 request held longer than one cycle");
    mdu1_once: assert property (@(posedge clk) disable iff (!rst_n)
        active[3] |=> o_lane_mdu1 != $past(o_lane_mdu1))
        else $error("MDU1 request held longer than one cycle");
    lsu_once: assert property (@(posedge clk) disable iff (!rst_n)
        active[4] |=> o_lane_lsu != $past(o_lane_lsu))
        else $error("LSU request held longer than one cycle");

    busy_needs_held: assert property (@(posedge clk) disable iff (!rst_n)
        !held_valid |-> !o_dec_busy)
        else $error("decoder stalled with nothing held");

endmodule

bind issue_top issue_props issue_props_inst (.*);

// File: tests/tb_issue_top.sv
// ##############################
// Issue stage testbench with
// reference model and watchdog
// ##############################
`timescale 1ns/1ps
`include "issue_defs.svh"

module tb_issue_top
    import isa_pkg::*;
    import issue_pkg::*;
();

    localparam int N_TOTAL = 1100;

    typedef struct packed {
        lane_class_t cls;
        lane_req_t   req;
        logic        pt;
        logic        strict;
        logic [31:0] cyc;
    } exp_t;

    logic                   clk = 1'b0;
    logic                   rst_n;
    logic                   i_flush;
    logic                   i_dec_valid;
    dec_instr_t             i_dec_instr;
    logic                   o_dec_busy;
    logic [`REG_ADDR_W-1:0] o_reg_ra0;
    logic [`REG_ADDR_W-1:0] o_reg_ra1;
    logic [`XLEN-1:0]       i_reg_rd0;
    logic [`XLEN-1:0]       i_reg_rd1;
    logic [`NUM_LANES-1:0]  i_lane_busy;
    lane_req_t              o_lane_alu;
    branch_req_t            o_lane_br;
    lane_req_t              o_lane_mdu0;
    lane_req_t              o_lane_mdu1;
    lane_req_t              o_lane_lsu;

    exp_t                  exp_q[$];
    logic [`NUM_LANES-1:0] prev_busy = '0;
    logic                  flush_pending = 1'b0;
    logic                  strict_timing = 1'b0;
    string                 test_name = "reset";
    int unsigned           cyc = 0;
    int unsigned           errors = 0;
    int unsigned           checks = 0;
    int unsigned           issued = 0;
    int unsigned           busy_cycles = 0;

    always #2 clk = ~clk;

    always @(posedge clk) cyc <= cyc + 1;

    // Register file model answers in the same cycle
    function automatic logic [`XLEN-1:0] rf_value(input logic [`REG_ADDR_W-1:0] a);
        return `XLEN'(a) * 32'h01010101 + 32'd7;
    endfunction

    assign i_reg_rd0 = rf_value(o_reg_ra0);
    assign i_reg_rd1 = rf_value(o_reg_ra1);

    issue_top issue_top_inst (.*);

    function automatic lane_class_t class_of(input opcodes_t op);
        if (op inside {OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU, OP_SB, OP_SH, OP_SW})
            return CLS_LSU;
        if (op inside {OP_SLLI, OP_SRLI, OP_SRAI, OP_SLL, OP_SRL, OP_SRA, OP_MUL, OP_MULH,
                       OP_MULHU, OP_MULHSU, OP_DIV, OP_DIVU, OP_REM, OP_REMU})
            return CLS_MDU;
        if (op inside {OP_SLTI, OP_SLTIU, OP_JAL, OP_JALR, OP_SLT, OP_SLTU, OP_BEQ, OP_BNE,
                       OP_BLT, OP_BGE, OP_BLTU, OP_BGEU, OP_ECALL, OP_EBREAK, OP_MRET})
            return CLS_BR;
        return CLS_ALU;
    endfunction

    function automatic alu_cmd_t cmd_of(input opcodes_t op);
        case (op)
            OP_SUB: return C_SUB;
            OP_XORI, OP_XOR: return C_XOR;
            OP_ORI, OP_OR: return C_OR;
            OP_ANDI, OP_AND: return C_AND;
            OP_SLTI, OP_SLT: return C_SLT;
            OP_SLTIU, OP_SLTU: return C_SLTU;
            OP_BEQ: return C_BEQ;
            OP_BNE: return C_BNE;
            OP_BLT: return C_BLT;
            OP_BGE: return C_BGE;
            OP_BLTU: return C_BLTU;
            OP_BGEU: return C_BGEU;
            OP_JAL: return C_JAL;
            OP_JALR: return C_JALR;
            OP_ECALL: return C_ECALL;
            OP_EBREAK: return C_EBREAK;
            OP_MRET: return C_MRET;
            OP_SLLI, OP_SLL: return C_SLL;
            OP_SRLI, OP_SRL: return C_SRL;
            OP_SRAI, OP_SRA: return C_SRA;
            OP_MUL: return C_MUL;
            OP_MULH: return C_MULH;
            OP_MULHU: return C_MULHU;
            OP_MULHSU: return C_MULHSU;
            OP_DIV: return C_DIV;
            OP_DIVU: return C_DIVU;
            OP_REM: return C_REM;
            OP_REMU: return C_REMU;
            OP_LB: return C_LB;
            OP_LH: return C_LH;
            OP_LW: return C_LW;
            OP_LBU: return C_LBU;
            OP_LHU: return C_LHU;
            OP_SB: return C_SB;
            OP_SH: return C_SH;
            OP_SW: return C_SW;
            default: return C_ADD;
        endcase
    endfunction

    function automatic exp_t predict(input dec_instr_t d);
        exp_t e;
        logic imm_form;
        imm_form = d.opcode inside {OP_LUI, OP_AUIPC, OP_ADDI, OP_XORI, OP_ORI, OP_ANDI,
                                    OP_SLTI, OP_SLTIU, OP_JAL, OP_JALR,
                                    OP_SLLI, OP_SRLI, OP_SRAI};
        e.cls      = class_of(d.opcode);
        e.req.cmd  = cmd_of(d.opcode);
        e.req.arg0 = rf_value(d.rs1);
        e.req.arg1 = imm_form ? d.imm : rf_value(d.rs2);
        e.req.addr = d.addr;
        e.req.imm  = d.imm;
        e.req.rd   = (d.opcode inside {OP_NOP, OP_FENCE}) ? '0 : d.rd;
        e.pt       = d.branch_taken;
        e.strict   = strict_timing;
        e.cyc      = cyc;
        return e;
    endfunction

    task automatic check_val(input string what, input logic [159:0] exp, got);
        checks++;
        assert (exp === got) else begin
            errors++;
            $display("[FAIL] %s %s expected %h actual %h", test_name, what, exp, got);
        end
    endtask

    // Output monitor followed by acceptance bookkeeping for the coming edge
    always @(negedge clk) begin
        lane_req_t outs[`NUM_LANES];
        exp_t e;
        int exp_lane;
        logic exp_busy;
        outs[`LANE_ALU]  = o_lane_alu;
        outs[`LANE_BR]   = o_lane_br.req;
        outs[`LANE_MDU0] = o_lane_mdu0;
        outs[`LANE_MDU1] = o_lane_mdu1;
        outs[`LANE_LSU]  = o_lane_lsu;
        if (rst_n) begin
            if (o_dec_busy)
                busy_cycles++;
            if (flush_pending)
                check_val("predict_taken idle after flush", 0, o_lane_br.predict_taken);
            for (int l = 0; l < `NUM_LANES; l++) begin
                if (flush_pending)
                    check_val($sformatf("lane %0d idle after flush", l), '0, outs[l]);
                if (outs[l].cmd != C_NONE) begin
                    issued++;
                    assert (!prev_busy[l]) else begin
                        errors++;
                        $display("%s: lane %0d got a request while busy", test_name, l);
                    end
                    assert (exp_q.size() > 0) else begin
                        errors++;
                        $display("%s: request on lane %0d with nothing pending", test_name, l);
                    end
                    if (exp_q.size() > 0) begin
                        e = exp_q.pop_front();
                        case (e.cls)
                            CLS_BR: exp_lane = `LANE_BR;
                            CLS_LSU: exp_lane = `LANE_LSU;
                            CLS_MDU: exp_lane = prev_busy[`LANE_MDU0] ? `LANE_MDU1 : `LANE_MDU0;
                            default: exp_lane = `LANE_ALU;
                        endcase
                        check_val("lane", exp_lane, l);
                        check_val("cmd", e.req.cmd, outs[l].cmd);
                        check_val("rd", e.req.rd, outs[l].rd);
                        check_val("arg0", e.req.arg0, outs[l].arg0);
                        check_val("arg1", e.req.arg1, outs[l].arg1);
                        check_val("addr", e.req.addr, outs[l].addr);
                        check_val("imm", e.req.imm, outs[l].imm);
                        if (l == `LANE_BR)
                            check_val("predict_taken", e.pt, o_lane_br.predict_taken);
                        if (e.strict)
                            check_val("latency", 2, cyc - e.cyc);
                    end
                end
            end
            // Whatever is still queued sits in the hold register
            exp_busy = 1'b0;
            if (exp_q.size() > 0) begin
                e = exp_q[0];
                case (e.cls)
                    CLS_BR: exp_busy = i_lane_busy[`LANE_BR];
                    CLS_LSU: exp_busy = i_lane_busy[`LANE_LSU];
                    CLS_MDU: exp_busy = i_lane_busy[`LANE_MDU0] && i_lane_busy[`LANE_MDU1];
                    default: exp_busy = i_lane_busy[`LANE_ALU];
                endcase
            end
            check_val("dec_busy", exp_busy, o_dec_busy);
            flush_pending = 1'b0;
            // Flush drops everything not yet on a lane output
            if (i_flush) begin
                exp_q.delete();
                flush_pending = 1'b1;
            end else if (i_dec_valid && !o_dec_busy) begin
                exp_q.push_back(predict(i_dec_instr));
            end
        end
        prev_busy = i_lane_busy;
    end

    // Busy modes are 0 idle lanes, 1 MDU0 busy, 2 both MDUs mostly busy and 3 random busy
    task automatic run_phase(input string name, input int n, input int mode,
                             input bit flush_en, input bit mdu_only);
        int  sent;
        bit  hold;
        dec_instr_t d;
        test_name     = name;
        strict_timing = (mode == 0) && !flush_en;
        sent          = 0;
        while (sent < n) begin
            @(negedge clk);
            hold = i_dec_valid && o_dec_busy && !i_flush;
            if (i_dec_valid && !hold)
                sent++;
            @(posedge clk);
            if (!hold) begin
                d              = dec_instr_t'({$urandom(), $urandom(), $urandom(), $urandom()});
                d.opcode       = mdu_only ? opcodes_t'($urandom_range(41, 28))
                                          : opcodes_t'($urandom_range(49, 0));
                i_dec_instr <= d;
                i_dec_valid <= ($urandom_range(9, 0) < 8);
            end
            case (mode)
                1: i_lane_busy <= 5'b00100;
                2: i_lane_busy <= ($urandom_range(3, 0) != 0) ? 5'b01100 : 5'b00000;
                3: i_lane_busy <= `NUM_LANES'($urandom());
                default: i_lane_busy <= '0;
            endcase
            i_flush <= flush_en && ($urandom_range(15, 0) == 0);
        end
    endtask

    initial begin
        #(N_TOTAL * 20 * 4);
        $display("Watchdog expired before the tests completed");
        $display("Testbench failed");
        $finish;
    end

    initial begin
        int busy_before;
        void'($urandom(32'hcb57));
        rst_n       = 1'b0;
        i_flush     = 1'b0;
        i_dec_valid = 1'b0;
        i_dec_instr = '0;
        i_lane_busy = '0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_val("alu idle", '0, o_lane_alu);
        check_val("br idle", '0, o_lane_br);
        check_val("mdu0 idle", '0, o_lane_mdu0);
        check_val("mdu1 idle", '0, o_lane_mdu1);
        check_val("lsu idle", '0, o_lane_lsu);
        check_val("dec_busy", 0, o_dec_busy);

        run_phase("routing", 400, 0, 1'b0, 1'b0);
        run_phase("mdu_fallback", 100, 1, 1'b0, 1'b1);
        busy_before = busy_cycles;
        run_phase("mdu_both_busy", 100, 2, 1'b0, 1'b1);
        assert (busy_cycles > busy_before) else begin
            errors++;
            $display("o_dec_busy never rose with both MDU lanes busy");
        end
        run_phase("backpressure", 300, 3, 1'b0, 1'b0);
        run_phase("flush", 200, 3, 1'b1, 1'b0);

        // Drain the pipeline
        test_name = "drain";
        @(posedge clk);
        i_dec_valid <= 1'b0;
        i_lane_busy <= '0;
        i_flush     <= 1'b0;
        repeat (6) @(negedge clk);
        assert (exp_q.size() == 0) else begin
            errors++;
            $display("%0d expected requests never issued", exp_q.size());
        end

        $display("Checks %0d, requests %0d, errors %0d", checks, issued, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// File: vlog.f
+incdir+source
source/isa_pkg.sv
source/issue_pkg.sv
source/issue_hold_stage.sv
source/issue_classify.sv
source/issue_dispatch.sv
source/issue_lane_reg.sv
source/issue_top.sv
tests/issue_props.sv
tests/tb_issue_top.sv

// File: Bender.yml
package:
  name: issue_stage

export_include_dirs:
  - source

sources:
  - files:
      - source/isa_pkg.sv
      - source/issue_pkg.sv
      - source/issue_hold_stage.sv
      - source/issue_classify.sv
      - source/issue_dispatch.sv
      - source/issue_lane_reg.sv
      - source/issue_top.sv
  - target: test
    files:
      - tests/issue_props.sv
      - tests/tb_issue_top.sv
